//--- verilog/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// ========================================
// Cache geometry
// ========================================

// Byte address bits on the processor side
`define DC_ADDR_W 16

// Processor data word
`define DC_WORD_W 32

// Words in one cache line
`define DC_WORDS 4

// Sets per way
`define DC_SETS 16

// Associativity
`define DC_WAYS 4

`endif

//--- verilog/dcache_pkg.sv
`default_nettype none
`include "dcache_defs.svh"

package dcache_pkg;
    // Address fields from high to low bits are tag, index, offset and byte
    localparam int BYTE_W = 2;                       // Byte within word
    localparam int OFF_W  = $clog2(`DC_WORDS);
    localparam int IDX_W  = $clog2(`DC_SETS);
    localparam int TAG_W  = `DC_ADDR_W - IDX_W - OFF_W - BYTE_W;
    localparam int WAY_W  = $clog2(`DC_WAYS);
    localparam int LINE_W = `DC_WORD_W * `DC_WORDS;  // Word 0 in low bits

    // Field positions inside a byte address
    localparam int OFF_LSB = BYTE_W;
    localparam int IDX_LSB = OFF_LSB + OFF_W;
    localparam int TAG_LSB = IDX_LSB + IDX_W;

    typedef logic [`DC_ADDR_W-1:0]   addr_t;
    typedef logic [`DC_WORD_W-1:0]   word_t;
    typedef logic [`DC_WORD_W/8-1:0] be_t;
    typedef logic [LINE_W-1:0]       line_t;
    typedef logic [TAG_W-1:0]        tag_t;
    typedef logic [IDX_W-1:0]        index_t;
    typedef logic [OFF_W-1:0]        offset_t;
    typedef logic [WAY_W-1:0]        way_t;
    typedef logic [`DC_WAYS-1:0]     way_mask_t;  // One bit per way

    // Controller states
    typedef enum logic [2:0] {
        IDLE,       // Waiting for a strobe
        LOOKUP,     // Tags and lines out of the RAMs
        WB_REQ,     // Dirty victim going out
        WB_WAIT,    // Waiting for ack release
        FILL_REQ,   // Line read from memory
        FILL_WAIT   // Waiting for ack release, then ready
    } state_t;
endpackage

`default_nettype wire

//--- verilog/line_sram.sv
`default_nettype none
`include "dcache_defs.svh"

// Single-port RAM, registered read, read-before-write
module line_sram import dcache_pkg::*;
#(
    parameter type entry_t = line_t,    // Tag or whole line
    parameter int  DEPTH   = `DC_SETS
)
(
    input  logic   clk,
    input  logic   we_i,
    input  index_t addr_i,
    input  entry_t wdata_i,
    output entry_t rdata_o
);

    entry_t mem_q [DEPTH];  // One entry per set

    always_ff @(posedge clk)
    begin
        if (we_i)
        begin
            mem_q[addr_i] <= wdata_i;
        end
        rdata_o <= mem_q[addr_i];  // Old contents on a write cycle
    end

endmodule

`default_nettype wire

//--- verilog/fifo_victim.sv
`default_nettype none
`include "dcache_defs.svh"

// Round-robin victim pointer per set
module fifo_victim import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  index_t index_i,
    input  logic   advance_i,   // Fill of this set done
    output way_t   victim_o
);

    way_t cnt_q [`DC_SETS];  // Next way to replace

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < `DC_SETS; s++)
            begin
                cnt_q[s] <= '0;
            end
        end
        else if (advance_i)
        begin
            // Oldest fill is next out
            cnt_q[index_i] <= cnt_q[index_i] + 1'b1;  // Wraps after last way
        end
    end

    // Combinational lookup for the current set
    assign victim_o = cnt_q[index_i];

endmodule

`default_nettype wire

//--- verilog/way_array.sv
`default_nettype none
`include "dcache_defs.svh"

module way_array import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  index_t    index_i,
    input  tag_t      tag_i,         // Latched request tag
    input  line_t     wline_i,
    input  way_mask_t we_i,          // Ways written this cycle
    input  logic      set_valid_i,
    input  logic      set_dirty_i,
    input  logic      clear_dirty_i,
    input  way_t      victim_i,
    output logic      hit_o,
    output way_t      hit_way_o,
    output line_t     hit_line_o,
    output tag_t      vic_tag_o,
    output logic      vic_dirty_o,
    output line_t     vic_line_o
);

    tag_t                tag_rd  [`DC_WAYS];  // RAM outputs
    line_t               line_rd [`DC_WAYS];
    logic [`DC_WAYS-1:0] valid_q [`DC_SETS];
    logic [`DC_WAYS-1:0] dirty_q [`DC_SETS];
    index_t              rd_index_q;          // Set behind the RAM outputs
    way_mask_t           hit_vec;

    // ========================================
    // Tag and line RAMs
    // ========================================
    for (genvar w = 0; w < `DC_WAYS; w++)
    begin : g_way
        line_sram #(.entry_t(tag_t), .DEPTH(`DC_SETS)) u_tag (
            .clk     (clk),
            .we_i    (we_i[w]),
            .addr_i  (index_i),
            .wdata_i (tag_i),
            .rdata_o (tag_rd[w])
        );
        line_sram #(.entry_t(line_t), .DEPTH(`DC_SETS)) u_line (
            .clk     (clk),
            .we_i    (we_i[w]),
            .addr_i  (index_i),
            .wdata_i (wline_i),
            .rdata_o (line_rd[w])
        );
        // Valid flag taken from the same set as the tag
        assign hit_vec[w] = valid_q[rd_index_q][w] && (tag_rd[w] == tag_i);
    end

    // ========================================
    // Valid and dirty flags
    // ========================================
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_index_q <= '0;
            for (int s = 0; s < `DC_SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end
        else
        begin
            rd_index_q <= index_i;
            for (int w = 0; w < `DC_WAYS; w++)
            begin
                if (we_i[w] && set_valid_i)
                    valid_q[index_i][w] <= 1'b1;
                if (we_i[w] && set_dirty_i)
                    dirty_q[index_i][w] <= 1'b1;   // Write hit or write fill
                else if (we_i[w] && clear_dirty_i)
                    dirty_q[index_i][w] <= 1'b0;   // Clean fill
            end
        end
    end

    // Hit way encoder
    always_comb
    begin
        hit_way_o = '0;
        for (int w = 0; w < `DC_WAYS; w++)
        begin
            if (hit_vec[w])
                hit_way_o = way_t'(w);
        end
    end

    assign hit_o       = |hit_vec;
    assign hit_line_o  = line_rd[hit_way_o];
    assign vic_tag_o   = tag_rd[victim_i];   // Needed for write-back address
    assign vic_line_o  = line_rd[victim_i];
    assign vic_dirty_o = dirty_q[rd_index_q][victim_i];

    // Fills only place tags that missed, so a set never holds a tag twice
    a_single_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec))
        else $error("way_array: more than one way hit");

endmodule

`default_nettype wire

//--- verilog/line_merge.sv
`default_nettype none
`include "dcache_defs.svh"

// Word pick and byte-masked word insert shared by hits and fills
module line_merge import dcache_pkg::*;
(
    input  line_t   base_i,     // Hit line or fill data
    input  offset_t offset_i,   // Word within the line
    input  be_t     be_i,       // All zero on reads
    input  word_t   wdata_i,
    output word_t   word_o,
    output line_t   line_o
);

    localparam int BYTES = `DC_WORD_W / 8;

    // Read path
    assign word_o = base_i[offset_i*`DC_WORD_W +: `DC_WORD_W];

    // Write path with any byte mask
    always_comb
    begin
        line_o = base_i;
        for (int b = 0; b < BYTES; b++)
        begin
            if (be_i[b])
            begin
                line_o[offset_i*`DC_WORD_W + b*8 +: 8] = wdata_i[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // Processor side
    input  logic      p_strobe_i,
    input  logic      p_rw_i,           // 1 for write
    input  addr_t     p_addr_i,
    input  be_t       p_be_i,
    input  word_t     p_wdata_i,
    // Way array, victim and merge results
    input  logic      hit_i,
    input  way_t      hit_way_i,
    input  line_t     hit_line_i,
    input  logic      vic_dirty_i,
    input  tag_t      vic_tag_i,
    input  line_t     vic_line_i,
    input  way_t      victim_i,
    input  word_t     merged_word_i,
    input  line_t     merged_line_i,
    // Memory side inputs
    input  logic      mem_ack_i,
    input  line_t     mem_rdata_i,
    // Datapath control
    output index_t    index_o,
    output tag_t      tag_o,
    output offset_t   offset_o,
    output be_t       be_o,
    output word_t     wdata_o,
    output line_t     base_line_o,
    output way_mask_t we_o,
    output logic      set_valid_o,
    output logic      set_dirty_o,
    output logic      clear_dirty_o,
    output logic      fill_done_o,
    // Processor outputs
    output logic      p_ready_o,
    output word_t     p_rdata_o,
    // Memory outputs
    output logic      mem_req_o,
    output logic      mem_we_o,
    output addr_t     mem_addr_o,
    output line_t     mem_wdata_o
);

    state_t  state_q;
    logic    rw_q;          // Request registers
    tag_t    tag_q;
    index_t  index_q;
    offset_t offset_q;
    be_t     be_q;
    word_t   wdata_q;
    line_t   fill_q;        // Filled line after the merge
    logic    hit_wr;
    logic    fill_wr;
    addr_t   fill_addr;
    addr_t   wb_addr;

    // ========================================
    // Datapath steering
    // ========================================
    assign hit_wr  = (state_q == LOOKUP) && hit_i && rw_q;
    assign fill_wr = (state_q == FILL_REQ) && mem_ack_i;    // Fill lands with ack

    assign fill_addr = {tag_q, index_q, {(OFF_W + BYTE_W){1'b0}}};
    assign wb_addr   = {vic_tag_i, index_q, {(OFF_W + BYTE_W){1'b0}}};

    // RAM read starts in IDLE straight from the bus
    assign index_o  = (state_q == IDLE) ? p_addr_i[IDX_LSB +: IDX_W] : index_q;
    assign tag_o    = tag_q;
    assign offset_o = offset_q;
    assign be_o     = rw_q ? be_q : '0;   // Reads leave the line untouched
    assign wdata_o  = wdata_q;

    assign we_o = hit_wr  ? way_mask_t'(1) << hit_way_i :
                  fill_wr ? way_mask_t'(1) << victim_i  : '0;
    assign set_valid_o   = fill_wr;
    assign set_dirty_o   = hit_wr || (fill_wr && rw_q);
    assign clear_dirty_o = fill_wr && !rw_q;
    assign fill_done_o   = fill_wr;     // Advances the set's FIFO

    always_comb
    begin
        case (state_q)
            FILL_REQ:  base_line_o = mem_rdata_i;
            FILL_WAIT: base_line_o = fill_q;
            default:   base_line_o = hit_line_i;
        endcase
    end

    // ========================================
    // State machine
    // ========================================
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q   <= IDLE;
            p_ready_o <= 1'b0;
            mem_req_o <= 1'b0;
            mem_we_o  <= 1'b0;
        end
        else
        begin
            p_ready_o <= 1'b0;  // One-cycle pulse
            case (state_q)
                IDLE:
                    if (p_strobe_i)
                        state_q <= LOOKUP;
                LOOKUP:
                    if (hit_i)
                    begin
                        p_ready_o <= 1'b1;
                        state_q   <= IDLE;
                    end
                    else
                    begin
                        mem_req_o <= 1'b1;
                        mem_we_o  <= vic_dirty_i;           // Write-back first
                        state_q   <= vic_dirty_i ? WB_REQ : FILL_REQ;
                    end
                WB_REQ:
                    if (mem_ack_i)
                    begin
                        mem_req_o <= 1'b0;
                        state_q   <= WB_WAIT;
                    end
                WB_WAIT:
                    if (!mem_ack_i)
                    begin
                        mem_req_o <= 1'b1;                  // Fill read
                        mem_we_o  <= 1'b0;
                        state_q   <= FILL_REQ;
                    end
                FILL_REQ:
                    if (mem_ack_i)
                    begin
                        mem_req_o <= 1'b0;
                        state_q   <= FILL_WAIT;
                    end
                FILL_WAIT:
                    if (!mem_ack_i)
                    begin
                        p_ready_o <= 1'b1;
                        state_q   <= IDLE;
                    end
                default:
                    state_q <= IDLE;
            endcase
        end
    end

    // Request, memory payload and read data registers
    always_ff @(posedge clk)
    begin
        if ((state_q == IDLE) && p_strobe_i)
        begin
            rw_q     <= p_rw_i;
            tag_q    <= p_addr_i[TAG_LSB +: TAG_W];
            index_q  <= p_addr_i[IDX_LSB +: IDX_W];
            offset_q <= p_addr_i[OFF_LSB +: OFF_W];
            be_q     <= p_be_i;
            wdata_q  <= p_wdata_i;
        end
        if ((state_q == LOOKUP) && !hit_i)
        begin
            mem_addr_o  <= vic_dirty_i ? wb_addr : fill_addr;
            mem_wdata_o <= vic_line_i;      // Ignored on a clean miss
        end
        if ((state_q == WB_WAIT) && !mem_ack_i)
            mem_addr_o <= fill_addr;
        if (fill_wr)
            fill_q <= merged_line_i;
        if (!rw_q && (((state_q == LOOKUP) && hit_i) ||
                      ((state_q == FILL_WAIT) && !mem_ack_i)))
            p_rdata_o <= merged_word_i;     // Held until the next read completes
    end

    // Memory must see a steady request until it acknowledges
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o) &&
                                    $stable(mem_we_o) && $stable(mem_wdata_o))
        else $error("dcache_ctrl: memory request changed before ack");

    // One outstanding request per processor
    a_strobe_idle: assert property (@(posedge clk) disable iff (rst)
        p_strobe_i |-> state_q == IDLE)
        else $error("dcache_ctrl: strobe while busy");

endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
`default_nettype none

// 4-way write-back data cache
module dcache_top import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    // Processor
    input  logic  p_strobe_i,
    input  logic  p_rw_i,
    input  addr_t p_addr_i,
    input  be_t   p_be_i,
    input  word_t p_wdata_i,
    output logic  p_ready_o,
    output word_t p_rdata_o,
    // Memory, four-phase req/ack
    output logic  mem_req_o,
    output logic  mem_we_o,
    output addr_t mem_addr_o,
    output line_t mem_wdata_o,
    input  logic  mem_ack_i,
    input  line_t mem_rdata_i
);

    index_t    index;
    tag_t      tag;
    offset_t   offset;
    be_t       be;
    word_t     wdata;
    line_t     base_line;
    way_mask_t we;
    logic      set_valid;
    logic      set_dirty;
    logic      clear_dirty;
    logic      fill_done;
    logic      hit;
    way_t      hit_way;
    line_t     hit_line;
    tag_t      vic_tag;
    logic      vic_dirty;
    line_t     vic_line;
    way_t      victim;
    word_t     merged_word;
    line_t     merged_line;

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .p_strobe_i    (p_strobe_i),
        .p_rw_i        (p_rw_i),
        .p_addr_i      (p_addr_i),
        .p_be_i        (p_be_i),
        .p_wdata_i     (p_wdata_i),
        .hit_i         (hit),
        .hit_way_i     (hit_way),
        .hit_line_i    (hit_line),
        .vic_dirty_i   (vic_dirty),
        .vic_tag_i     (vic_tag),
        .vic_line_i    (vic_line),
        .victim_i      (victim),
        .merged_word_i (merged_word),
        .merged_line_i (merged_line),
        .mem_ack_i     (mem_ack_i),
        .mem_rdata_i   (mem_rdata_i),
        .index_o       (index),
        .tag_o         (tag),
        .offset_o      (offset),
        .be_o          (be),
        .wdata_o       (wdata),
        .base_line_o   (base_line),
        .we_o          (we),
        .set_valid_o   (set_valid),
        .set_dirty_o   (set_dirty),
        .clear_dirty_o (clear_dirty),
        .fill_done_o   (fill_done),
        .p_ready_o     (p_ready_o),
        .p_rdata_o     (p_rdata_o),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o)
    );

    // Merged line feeds the RAM write port directly
    way_array u_ways (
        .clk           (clk),
        .rst           (rst),
        .index_i       (index),
        .tag_i         (tag),
        .wline_i       (merged_line),
        .we_i          (we),
        .set_valid_i   (set_valid),
        .set_dirty_i   (set_dirty),
        .clear_dirty_i (clear_dirty),
        .victim_i      (victim),
        .hit_o         (hit),
        .hit_way_o     (hit_way),
        .hit_line_o    (hit_line),
        .vic_tag_o     (vic_tag),
        .vic_dirty_o   (vic_dirty),
        .vic_line_o    (vic_line)
    );

    fifo_victim u_victim (
        .clk       (clk),
        .rst       (rst),
        .index_i   (index),
        .advance_i (fill_done),
        .victim_o  (victim)
    );

    line_merge u_merge (
        .base_i   (base_line),
        .offset_i (offset),
        .be_i     (be),
        .wdata_i  (wdata),
        .word_o   (merged_word),
        .line_o   (merged_line)
    );

endmodule

`default_nettype wire

//--- tests/tb_dcache.sv
`default_nettype none
`include "dcache_defs.svh"

module tb_dcache import dcache_pkg::*;
();

    localparam int N_PAIRS = 16;     // Hit latency pairs
    localparam int N_WR    = 24;     // Byte-masked writes
    localparam int N_MIX   = 300;    // Long random mix
    localparam int N_REQ   = 2 + 2 * N_PAIRS + N_WR + 8 + 7 + 6 + N_MIX + 16;
    localparam int MAX_CYC = 10 + 40 * N_REQ;   // 40 cycles covers a dirty miss
    localparam int LINES   = 1 << (`DC_ADDR_W - IDX_LSB);
    localparam logic [31:0] POLY = 32'h8020_0003;

    logic  clk = 1'b0;
    logic  rst;
    logic  p_strobe;
    logic  p_rw;
    addr_t p_addr;
    be_t   p_be;
    word_t p_wdata;
    logic  p_ready;
    word_t p_rdata;
    logic  mem_req;
    logic  mem_we;
    addr_t mem_addr;
    line_t mem_wdata;
    logic  mem_ack;
    line_t mem_rdata;

    logic [7:0]  model_q [1 << `DC_ADDR_W];  // Processor view by byte
    line_t       mem_q [LINES];              // Backing memory behind the responder
    logic [31:0] lfsr_q = 32'h7fb7;          // Stimulus stream
    logic [31:0] ack_lfsr_q = 32'h7fb7;      // Responder delay stream
    int          errors = 0;
    int          checks = 0;
    int          test_base = 0;
    int          wr_cnt = 0;                 // Write-backs seen by memory
    int          rd_cnt = 0;                 // Fills seen by memory
    int          cycle_cnt = 0;
    addr_t       last_wb_addr;

    always #2 clk = ~clk;

    dcache_top uut (
        .clk         (clk),
        .rst         (rst),
        .p_strobe_i  (p_strobe),
        .p_rw_i      (p_rw),
        .p_addr_i    (p_addr),
        .p_be_i      (p_be),
        .p_wdata_i   (p_wdata),
        .p_ready_o   (p_ready),
        .p_rdata_o   (p_rdata),
        .mem_req_o   (mem_req),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_ack_i   (mem_ack),
        .mem_rdata_i (mem_rdata)
    );

    // ========================================
    // Random numbers, model and checks
    // ========================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ POLY) : (s >> 1);   // Galois form
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};   // One step per bit
        end
        return v;
    endfunction

    function automatic int rand_delay();
        logic [1:0] v;
        v = '0;
        for (int i = 0; i < 2; i++)
        begin
            ack_lfsr_q = lfsr_next(ack_lfsr_q);
            v = {v[0], ack_lfsr_q[0]};
        end
        return int'(v);                 // 0 to 3 cycles
    endfunction

    // Initial memory byte mixing all address bits
    function automatic logic [7:0] init_byte(input addr_t a);
        return (a[7:0] + a[15:8] * 8'd131) ^ 8'h3c;
    endfunction

    function automatic addr_t make_addr(input tag_t t, input index_t i, input offset_t o);
        return {t, i, o, {BYTE_W{1'b0}}};
    endfunction

    function automatic word_t model_word(input addr_t a);
        addr_t base;
        word_t w;
        base = {a[`DC_ADDR_W-1:OFF_LSB], {BYTE_W{1'b0}}};
        for (int b = 0; b < 4; b++)
            w[b*8 +: 8] = model_q[base + addr_t'(b)];   // Little endian
        return w;
    endfunction

    function automatic line_t model_line(input addr_t a);
        addr_t base;
        line_t l;
        base = {a[`DC_ADDR_W-1:IDX_LSB], {IDX_LSB{1'b0}}};
        for (int i = 0; i < line_bytes(); i++)
            l[i*8 +: 8] = model_q[base + addr_t'(i)];   // Word 0 low
        return l;
    endfunction

    function automatic int line_bytes();
        return `DC_WORDS * `DC_WORD_W / 8;
    endfunction

    task automatic model_write(input addr_t a, input be_t be, input word_t wd);
        addr_t base;
        base = {a[`DC_ADDR_W-1:OFF_LSB], {BYTE_W{1'b0}}};
        for (int b = 0; b < 4; b++)
        begin
            if (be[b])
                model_q[base + addr_t'(b)] = wd[b*8 +: 8];
        end
    endtask

    task automatic check_val(input string name, input line_t got, input line_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic test_done(input string name);
        $display("test %s done, %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;                               // Inputs move after the edge
    endtask

    // One processor request through to its ready pulse
    task automatic access(input logic rw, input addr_t a, input be_t be, input word_t wd,
                          output int lat, output int missed);
        p_strobe = 1'b1;
        p_rw     = rw;
        p_addr   = a;
        p_be     = be;
        p_wdata  = wd;
        missed   = 0;
        next_cycle();
        p_strobe = 1'b0;
        lat      = 1;
        while (!p_ready)
        begin
            if (mem_req)
                missed = 1;
            next_cycle();
            lat++;
        end
        if (rw)
            model_write(a, be, wd);       // Applied once the write completes
        else
            check_val("p_rdata_o", line_t'(p_rdata), line_t'(model_word(a)));
    endtask

    // ========================================
    // Four-phase req/ack memory responder
    // ========================================
    task automatic serve_mem();
        check_val("mem_addr_o low bits", line_t'(mem_addr[IDX_LSB-1:0]), '0);
        if (mem_we)
        begin
            wr_cnt++;
            last_wb_addr = mem_addr;
            check_val("mem_wdata_o", mem_wdata, model_line(mem_addr));
            mem_q[mem_addr[`DC_ADDR_W-1:IDX_LSB]] = mem_wdata;
        end
        else
        begin
            rd_cnt++;
            mem_rdata = mem_q[mem_addr[`DC_ADDR_W-1:IDX_LSB]];
        end
    endtask

    initial
    begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever
        begin
            next_cycle();
            if (!rst && mem_req)
            begin
                repeat (rand_delay())
                    next_cycle();         // Late ack
                serve_mem();
                mem_ack = 1'b1;
                while (mem_req)
                    next_cycle();
                repeat (rand_delay())
                    next_cycle();         // Late release
                mem_ack = 1'b0;
            end
        end
    end

    // Run limit
    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYC)
        begin
            $display("timeout: no end of test after %0d cycles", MAX_CYC);
            $display("TB FAILED");
            $finish;
        end
    end

    // ========================================
    // Tests
    // ========================================
    task automatic reset_test();
        int lat;
        int missed;
        check_val("p_ready_o", line_t'(p_ready), '0);
        check_val("mem_req_o", line_t'(mem_req), '0);
        check_val("mem_we_o", line_t'(mem_we), '0);
        access(1'b0, make_addr(8'h90, 4'd0, 2'd1), '0, '0, lat, missed);   // Cold lines
        access(1'b0, make_addr(8'h91, 4'd2, 2'd3), '0, '0, lat, missed);
        test_done("reset");
    endtask

    task automatic hit_test();
        logic [31:0] r;
        addr_t       a;
        int          lat;
        int          missed;
        for (int i = 0; i < N_PAIRS; i++)
        begin
            r = rand_bits(14);
            a = make_addr({1'b0, r[12:6]}, r[5:2], r[1:0]);   // Tags below 0x80
            access(r[13], a, be_t'(rand_bits(4)), rand_bits(32), lat, missed);
            a[OFF_LSB +: OFF_W] = offset_t'(rand_bits(2));    // Same line
            access(1'b0, a, '0, '0, lat, missed);
            check_val("p_ready_o latency", line_t'(lat), line_t'(2));
            check_val("mem_req_o on hit", line_t'(missed), '0);
        end
        test_done("hit");
    endtask

    task automatic byte_mask_test();
        logic [31:0] r;
        tag_t        t;
        index_t      idx;
        int          lat;
        int          missed;
        r   = rand_bits(11);
        t   = {1'b0, r[6:0]};
        idx = r[10:7];
        for (int i = 0; i < N_WR; i++)
        begin
            r = rand_bits(3);             // Two lines and any word
            access(1'b1, make_addr(t, idx + index_t'(r[2]), r[1:0]),
                   be_t'(rand_bits(4)), rand_bits(32), lat, missed);
        end
        for (int k = 0; k < 8; k++)
            access(1'b0, make_addr(t, idx + index_t'(k / 4), offset_t'(k % 4)), '0, '0,
                   lat, missed);
        test_done("byte_mask");
    endtask

    task automatic fifo_order_test();
        int lat;
        int missed;
        for (int t = 0; t < 5; t++)
        begin
            access(1'b0, make_addr(8'hf0 + tag_t'(t), 4'd3, 2'd0), '0, '0, lat, missed);
            check_val("mem_req_o on cold read", line_t'(missed), line_t'(1));
        end
        access(1'b0, make_addr(8'hf0, 4'd3, 2'd1), '0, '0, lat, missed);   // Oldest gone
        check_val("mem_req_o on evicted line", line_t'(missed), line_t'(1));
        access(1'b0, make_addr(8'hf2, 4'd3, 2'd2), '0, '0, lat, missed);
        check_val("mem_req_o on kept line", line_t'(missed), '0);
        check_val("p_ready_o latency", line_t'(lat), line_t'(2));
        test_done("fifo");
    endtask

    task automatic evict_test();
        int lat;
        int missed;
        int wr0;
        int rd0;
        access(1'b1, make_addr(8'he0, 4'd7, 2'd1), be_t'(rand_bits(4)), rand_bits(32),
               lat, missed);
        for (int t = 1; t < 4; t++)
            access(1'b0, make_addr(8'he0 + tag_t'(t), 4'd7, 2'd0), '0, '0, lat, missed);
        wr0 = wr_cnt;
        access(1'b0, make_addr(8'he4, 4'd7, 2'd0), '0, '0, lat, missed);   // Evicts dirty e0
        check_val("memory writes on dirty eviction", line_t'(wr_cnt - wr0), line_t'(1));
        check_val("write-back address", line_t'(last_wb_addr),
                  line_t'(make_addr(8'he0, 4'd7, 2'd0)));
        wr0 = wr_cnt;
        rd0 = rd_cnt;
        access(1'b0, make_addr(8'he5, 4'd7, 2'd0), '0, '0, lat, missed);   // Evicts clean e1
        check_val("memory writes on clean eviction", line_t'(wr_cnt - wr0), '0);
        check_val("memory reads on clean eviction", line_t'(rd_cnt - rd0), line_t'(1));
        test_done("evict");
    endtask

    task automatic random_mix_test();
        logic [31:0] r;
        addr_t       a;
        int          lat;
        int          missed;
        for (int i = 0; i < N_MIX; i++)
        begin
            r = rand_bits(8);             // Sets 1, 5, 9, 13 and eight tags
            a = make_addr({5'b0, r[4:2]}, {r[1:0], 2'b01}, r[6:5]);
            access(r[7], a, be_t'(rand_bits(4)), rand_bits(32), lat, missed);
        end
        // Flush with four fresh tags per set
        for (int s = 0; s < 4; s++)
        begin
            for (int t = 0; t < 4; t++)
                access(1'b0, make_addr(8'hc0 + tag_t'(t), {s[1:0], 2'b01}, 2'd0), '0, '0,
                       lat, missed);
        end
        for (int s = 0; s < 4; s++)
        begin
            for (int t = 0; t < 8; t++)
            begin
                a = make_addr(tag_t'(t), {s[1:0], 2'b01}, 2'd0);
                check_val("memory line", mem_q[a[`DC_ADDR_W-1:IDX_LSB]], model_line(a));
            end
        end
        test_done("random_mix");
    endtask

    initial
    begin
        for (int i = 0; i < (1 << `DC_ADDR_W); i++)
            model_q[i] = init_byte(addr_t'(i));
        for (int l = 0; l < LINES; l++)
            mem_q[l] = model_line(addr_t'(l << IDX_LSB));   // Same pattern as model
        rst      = 1'b1;
        p_strobe = 1'b0;
        p_rw     = 1'b0;
        p_addr   = '0;
        p_be     = '0;
        p_wdata  = '0;
        repeat (2)
            @(posedge clk);
        #1;
        rst = 1'b0;
        reset_test();
        hit_test();
        byte_mask_test();
        fifo_order_test();
        evict_test();
        random_mix_test();
        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/line_sram.sv
verilog/fifo_victim.sv
verilog/way_array.sv
verilog/line_merge.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tests/tb_dcache.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module tb_dcache -f vlog.f \
		--Mdir obj_dir -o sim_dcache
	./obj_dir/sim_dcache | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
